/* hdl/coreCfgPkg.sv */
package coreCfgPkg;

    // ALU operation codes
    localparam int aluFuncW = 3;

    localparam logic [aluFuncW-1:0] aluAdd   = 3'd0;
    localparam logic [aluFuncW-1:0] aluSub   = 3'd1;
    localparam logic [aluFuncW-1:0] aluAnd   = 3'd2;
    localparam logic [aluFuncW-1:0] aluOr    = 3'd3;
    localparam logic [aluFuncW-1:0] aluXor   = 3'd4;
    localparam logic [aluFuncW-1:0] aluSlt   = 3'd5;
    localparam logic [aluFuncW-1:0] aluPassB = 3'd6;

    // Operand source in execute
    localparam logic fwdReg = 1'b0;
    localparam logic fwdWb  = 1'b1;

    // First fetch address
    localparam logic [31:0] resetPc = 32'h0000_0000;

endpackage

/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic                               cpuClk,
    input  logic                               rstN,
    input  rvIsaPkg::rvInstr                   idInstr,
    input  logic [rvIsaPkg::xlen-1:0]          idPc,
    input  logic                               idValid,
    input  logic [rvIsaPkg::xlen-1:0]          rdData1,
    input  logic [rvIsaPkg::xlen-1:0]          rdData2,
    output logic [rvIsaPkg::regAddrW-1:0]      rs1,
    output logic [rvIsaPkg::regAddrW-1:0]      rs2,
    output logic [rvIsaPkg::xlen-1:0]          exPc,
    output logic [rvIsaPkg::xlen-1:0]          exOpA,
    output logic [rvIsaPkg::xlen-1:0]          exOpB,
    output logic [rvIsaPkg::xlen-1:0]          exImm,
    output logic [rvIsaPkg::regAddrW-1:0]      exRd,
    output logic [coreCfgPkg::aluFuncW-1:0]    exAluFunc,
    output logic                               exUseImm,
    output logic                               exIsBranch,
    output logic                               exBranchNe,
    output logic                               exWrite,
    pipeCtrlIf.dec                             ctrl
);
    import rvIsaPkg::*;
    import coreCfgPkg::*;

    logic [xlen-1:0]     immI;
    logic [xlen-1:0]     immU;
    logic [xlen-1:0]     immB;
    logic [xlen-1:0]     imm;
    logic [aluFuncW-1:0] aluFunc;
    logic                useImm;
    logic                isBranch;
    logic                writeRd;
    logic                keep;

    assign rs1 = idInstr.r.rs1;
    assign rs2 = idInstr.r.rs2;

    assign immI = {{20{idInstr.i.imm12[11]}}, idInstr.i.imm12};
    assign immU = {idInstr.u.imm20, 12'b0};
    assign immB = {{20{idInstr.b.imm12}}, idInstr.b.imm11, idInstr.b.imm10to5,
                   idInstr.b.imm4to1, 1'b0};

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        aluFunc  = aluAdd;
        imm      = immI;
        useImm   = 1'b0;
        isBranch = 1'b0;
        writeRd  = 1'b0;
        case (idInstr.r.opcode)
            opOp, opOpImm: begin
                writeRd = 1'b1;
                useImm  = (idInstr.r.opcode == opOpImm);
                case (idInstr.i.funct3)
                    f3AddSub: aluFunc = aluAdd;
                    f3Slt:    aluFunc = aluSlt;
                    f3Xor:    aluFunc = aluXor;
                    f3Or:     aluFunc = aluOr;
                    f3And:    aluFunc = aluAnd;
                    default:  writeRd = 1'b0;
                endcase
                // Register form also checks funct7
                if (!useImm) begin
                    if (idInstr.r.funct7 == f7Sub && idInstr.r.funct3 == f3AddSub) begin
                        aluFunc = aluSub;
                    end else if (idInstr.r.funct7 != f7Base) begin
                        writeRd = 1'b0;
                    end
                end
            end
            opLui: begin
                aluFunc = aluPassB;
                imm     = immU;
                useImm  = 1'b1;
                writeRd = 1'b1;
            end
            opBranch: begin
                imm      = immB;
                isBranch = (idInstr.b.funct3 == f3Beq) || (idInstr.b.funct3 == f3Bne);
            end
            default: begin
                // Anything else passes through as a no-op
                writeRd = 1'b0;
            end
        endcase
    end

    assign keep = idValid && !ctrl.flushDecode;

    always_ff @(posedge cpuClk or negedge rstN) begin
        if (!rstN) begin
            ctrl.exValid <= 1'b0;
            exWrite      <= 1'b0;
            exIsBranch   <= 1'b0;
        end else begin
            ctrl.exValid <= keep;
            exWrite      <= keep && writeRd;
            exIsBranch   <= keep && isBranch;
        end
    end

    // Decode-to-execute payload
    always_ff @(posedge cpuClk) begin
        exPc       <= idPc;
        exOpA      <= rdData1;
        exOpB      <= rdData2;
        exImm      <= imm;
        exRd       <= idInstr.r.rd;
        exAluFunc  <= aluFunc;
        exUseImm   <= useImm;
        exBranchNe <= (idInstr.b.funct3 == f3Bne);
        ctrl.exRs1 <= idInstr.r.rs1;
        ctrl.exRs2 <= idInstr.r.rs2;
    end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic                               cpuClk,
    input  logic                               rstN,
    input  logic [rvIsaPkg::xlen-1:0]          exPc,
    input  logic [rvIsaPkg::xlen-1:0]          exOpA,
    input  logic [rvIsaPkg::xlen-1:0]          exOpB,
    input  logic [rvIsaPkg::xlen-1:0]          exImm,
    input  logic [rvIsaPkg::regAddrW-1:0]      exRd,
    input  logic [coreCfgPkg::aluFuncW-1:0]    exAluFunc,
    input  logic                               exUseImm,
    input  logic                               exIsBranch,
    input  logic                               exBranchNe,
    input  logic                               exWrite,
    output logic [rvIsaPkg::xlen-1:0]          branchTarget,
    output logic [rvIsaPkg::regAddrW-1:0]      wrAddr,
    output logic [rvIsaPkg::xlen-1:0]          wrData,
    output logic                               wrEn,
    output logic                               retireValid,
    output logic [rvIsaPkg::xlen-1:0]          retirePc,
    output logic [rvIsaPkg::regAddrW-1:0]      retireRd,
    output logic [rvIsaPkg::xlen-1:0]          retireData,
    pipeCtrlIf.exe                             ctrl
);
    import rvIsaPkg::*;
    import coreCfgPkg::*;

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluOut;

    // ------------------------------
    // Operand select and ALU
    // ------------------------------
    assign opA  = (ctrl.fwdSel1 == fwdWb) ? wrData : exOpA;
    assign opB  = (ctrl.fwdSel2 == fwdWb) ? wrData : exOpB;
    assign aluB = exUseImm ? exImm : opB;

    always_comb begin
        case (exAluFunc)
            aluAdd:   aluOut = opA + aluB;
            aluSub:   aluOut = opA - aluB;
            aluAnd:   aluOut = opA & aluB;
            aluOr:    aluOut = opA | aluB;
            aluXor:   aluOut = opA ^ aluB;
            aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(aluB)};
            aluPassB: aluOut = aluB;
            default:  aluOut = '0;
        endcase
    end

    // BEQ on equal, BNE on different
    assign ctrl.branchTaken = ctrl.exValid && exIsBranch && ((opA == opB) != exBranchNe);
    assign branchTarget     = exPc + exImm;

    // ------------------------------
    // Writeback register
    // ------------------------------
    always_ff @(posedge cpuClk or negedge rstN) begin
        if (!rstN) begin
            wrEn        <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            wrEn        <= ctrl.exValid && exWrite;
            retireValid <= ctrl.exValid;
        end
    end

    always_ff @(posedge cpuClk) begin
        wrAddr   <= exRd;
        wrData   <= aluOut;
        retirePc <= exPc;
    end

    assign ctrl.wbRd    = wrAddr;
    assign ctrl.wbWrite = wrEn;

    // Branches and no-ops report nothing written
    assign retireRd   = wrEn ? wrAddr : '0;
    assign retireData = wrEn ? wrData : '0;

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic                          cpuClk,
    input  logic                          rstN,
    input  logic [rvIsaPkg::xlen-1:0]     wbDatI,
    input  logic                          wbAck,
    input  logic [rvIsaPkg::xlen-1:0]     branchTarget,
    output logic                          wbCyc,
    output logic                          wbStb,
    output logic [rvIsaPkg::xlen-1:0]     wbAdr,
    output rvIsaPkg::rvInstr              idInstr,
    output logic [rvIsaPkg::xlen-1:0]     idPc,
    output logic                          idValid,
    pipeCtrlIf.fetch                      ctrl
);
    import rvIsaPkg::*;
    import coreCfgPkg::*;

    logic [xlen-1:0] pc;
    logic            reqActive;
    // Set when a branch redirects while a request is still waiting
    logic            discard;

    assign wbCyc = reqActive;
    assign wbStb = reqActive;

    // ------------------------------
    // Request state and PC
    // ------------------------------
    always_ff @(posedge cpuClk or negedge rstN) begin
        if (!rstN) begin
            pc        <= resetPc;
            wbAdr     <= resetPc;
            reqActive <= 1'b0;
            discard   <= 1'b0;
            idValid   <= 1'b0;
        end else begin
            idValid <= 1'b0;
            if (reqActive) begin
                if (wbAck) begin
                    reqActive <= 1'b0;
                    discard   <= 1'b0;
                    if (!discard && !ctrl.flushFetch) begin
                        idValid <= 1'b1;
                        pc      <= pc + 32'd4;
                    end
                end else if (ctrl.flushFetch) begin
                    discard <= 1'b1;
                end
            end else begin
                // One idle cycle between requests
                reqActive <= 1'b1;
                wbAdr     <= ctrl.flushFetch ? branchTarget : pc;
            end
            if (ctrl.flushFetch) begin
                pc <= branchTarget;
            end
        end
    end

    // Fetch-to-decode payload
    always_ff @(posedge cpuClk) begin
        if (reqActive && wbAck) begin
            idInstr <= wbDatI;
            idPc    <= wbAdr;
        end
    end

    // Classic cycle holds address and strobe until the acknowledge
    assert property (@(posedge cpuClk) disable iff (!rstN)
        wbStb && !wbAck |=> $stable(wbAdr) && wbStb && wbCyc);

endmodule

/* hdl/pipeControl.sv */
`timescale 1ns/1ps

module pipeControl (
    pipeCtrlIf.ctrl ctrl
);
    import rvIsaPkg::*;
    import coreCfgPkg::*;

    // Writeback holds a live result for this source register
    function automatic logic wbHit(
        input logic                valid,
        input logic                write,
        input logic [regAddrW-1:0] dest,
        input logic [regAddrW-1:0] src
    );
        return valid && write && (dest != '0) && (dest == src);
    endfunction

    // Branch resolves in execute, both younger slots are dropped
    assign ctrl.flushFetch  = ctrl.branchTaken;
    assign ctrl.flushDecode = ctrl.branchTaken;

    assign ctrl.fwdSel1 = wbHit(ctrl.exValid, ctrl.wbWrite, ctrl.wbRd, ctrl.exRs1) ?
                          fwdWb : fwdReg;
    assign ctrl.fwdSel2 = wbHit(ctrl.exValid, ctrl.wbWrite, ctrl.wbRd, ctrl.exRs2) ?
                          fwdWb : fwdReg;

    // x0 results from execute are never forwarded
    assert property (@(posedge ctrl.cpuClk)
        (ctrl.wbRd == '0) |-> (ctrl.fwdSel1 == fwdReg) && (ctrl.fwdSel2 == fwdReg));

endmodule

/* hdl/pipeCtrlIf.sv */
`timescale 1ns/1ps

interface pipeCtrlIf (
    input logic cpuClk
);
    import rvIsaPkg::*;

    // Hazard inputs from the stages
    logic [regAddrW-1:0] exRs1;
    logic [regAddrW-1:0] exRs2;
    logic                exValid;
    logic [regAddrW-1:0] wbRd;
    logic                wbWrite;
    logic                branchTaken;

    // Controls back to the stages
    logic flushFetch;
    logic flushDecode;
    logic fwdSel1;
    logic fwdSel2;

    modport ctrl (
        input  cpuClk, exRs1, exRs2, exValid, wbRd, wbWrite, branchTaken,
        output flushFetch, flushDecode, fwdSel1, fwdSel2
    );
    modport fetch (input flushFetch);
    modport dec (input flushDecode, output exRs1, exRs2, exValid);
    modport exe (input exValid, fwdSel1, fwdSel2, output wbRd, wbWrite, branchTaken);

endinterface

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                          cpuClk,
    input  logic                          rstN,
    input  logic [rvIsaPkg::regAddrW-1:0] rs1,
    input  logic [rvIsaPkg::regAddrW-1:0] rs2,
    input  logic [rvIsaPkg::regAddrW-1:0] wrAddr,
    input  logic [rvIsaPkg::xlen-1:0]     wrData,
    input  logic                          wrEn,
    output logic [rvIsaPkg::xlen-1:0]     rdData1,
    output logic [rvIsaPkg::xlen-1:0]     rdData2
);
    import rvIsaPkg::*;

    logic [xlen-1:0] regs [1 << regAddrW];
    logic            wrLive;

    // x0 is never written, so the write-through must skip it too
    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge cpuClk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < (1 << regAddrW); k++) begin
                regs[k] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdData1 = (wrLive && wrAddr == rs1) ? wrData : regs[rs1];
    assign rdData2 = (wrLive && wrAddr == rs2) ? wrData : regs[rs2];

    assert property (@(posedge cpuClk) (rs1 == '0) |-> (rdData1 == '0));
    assert property (@(posedge cpuClk) (rs2 == '0) |-> (rdData2 == '0));

endmodule

/* hdl/rv32Core.sv */
`timescale 1ns/1ps

module rv32Core (
    input  logic                          cpuClk,
    input  logic                          rstN,
    output logic                          wbCyc,
    output logic                          wbStb,
    output logic [rvIsaPkg::xlen-1:0]     wbAdr,
    input  logic [rvIsaPkg::xlen-1:0]     wbDatI,
    input  logic                          wbAck,
    output logic                          retireValid,
    output logic [rvIsaPkg::xlen-1:0]     retirePc,
    output logic [rvIsaPkg::regAddrW-1:0] retireRd,
    output logic [rvIsaPkg::xlen-1:0]     retireData
);
    import rvIsaPkg::*;
    import coreCfgPkg::*;

    rvInstr              idInstr;
    logic [xlen-1:0]     idPc;
    logic                idValid;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [xlen-1:0]     rdData1;
    logic [xlen-1:0]     rdData2;
    logic [xlen-1:0]     exPc;
    logic [xlen-1:0]     exOpA;
    logic [xlen-1:0]     exOpB;
    logic [xlen-1:0]     exImm;
    logic [regAddrW-1:0] exRd;
    logic [aluFuncW-1:0] exAluFunc;
    logic                exUseImm;
    logic                exIsBranch;
    logic                exBranchNe;
    logic                exWrite;
    logic [xlen-1:0]     branchTarget;
    logic [regAddrW-1:0] wrAddr;
    logic [xlen-1:0]     wrData;
    logic                wrEn;

    pipeCtrlIf i_pipeCtrl (.cpuClk(cpuClk));

    // ------------------------------
    // Stages
    // ------------------------------
    fetchUnit i_fetchUnit (
        .cpuClk(cpuClk), .rstN(rstN),
        .wbDatI(wbDatI), .wbAck(wbAck), .branchTarget(branchTarget),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
        .idInstr(idInstr), .idPc(idPc), .idValid(idValid),
        .ctrl(i_pipeCtrl.fetch)
    );

    registerFile i_registerFile (
        .cpuClk(cpuClk), .rstN(rstN),
        .rs1(rs1), .rs2(rs2),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn),
        .rdData1(rdData1), .rdData2(rdData2)
    );

    decodeStage i_decodeStage (
        .cpuClk(cpuClk), .rstN(rstN),
        .idInstr(idInstr), .idPc(idPc), .idValid(idValid),
        .rdData1(rdData1), .rdData2(rdData2),
        .rs1(rs1), .rs2(rs2),
        .exPc(exPc), .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm), .exRd(exRd),
        .exAluFunc(exAluFunc), .exUseImm(exUseImm), .exIsBranch(exIsBranch),
        .exBranchNe(exBranchNe), .exWrite(exWrite),
        .ctrl(i_pipeCtrl.dec)
    );

    executeStage i_executeStage (
        .cpuClk(cpuClk), .rstN(rstN),
        .exPc(exPc), .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm), .exRd(exRd),
        .exAluFunc(exAluFunc), .exUseImm(exUseImm), .exIsBranch(exIsBranch),
        .exBranchNe(exBranchNe), .exWrite(exWrite),
        .branchTarget(branchTarget),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireData(retireData),
        .ctrl(i_pipeCtrl.exe)
    );

    // Hazard control
    pipeControl i_pipeControl (
        .ctrl(i_pipeCtrl.ctrl)
    );

endmodule

/* hdl/rvIsaPkg.sv */
package rvIsaPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Major opcodes
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;

    // funct3, same codes for register and immediate forms
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    // One instruction word seen in the four formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
    } rvInstr;

endpackage

/* list.f */
hdl/rvIsaPkg.sv
hdl/coreCfgPkg.sv
hdl/pipeCtrlIf.sv
hdl/fetchUnit.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/pipeControl.sv
hdl/rv32Core.sv
test/clockGen.sv
test/tbRv32Core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rv32Core testbench with Verilator
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module tbRv32Core -Mdir "$buildDir" -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Test completed successfully" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk
);

    // 8 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

/* test/tbRv32Core.sv */
`timescale 1ns/1ps

module tbRv32Core;
    import rvIsaPkg::*;
    import coreCfgPkg::*;

    localparam int progLen       = 22;
    localparam int retireTimeout = 40;

    logic        cpuClk;
    logic        rstN;
    logic        wbCyc;
    logic        wbStb;
    logic [31:0] wbAdr;
    logic [31:0] wbDatI;
    logic        wbAck;
    logic        retireValid;
    logic [31:0] retirePc;
    logic [4:0]  retireRd;
    logic [31:0] retireData;

    logic        armed;
    logic [31:0] progMem [32];
    logic [31:0] expPcQ [$];
    logic [4:0]  expRdQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] headPc;
    logic [4:0]  headRd;
    logic [31:0] headData;
    integer      seed;

    clockGen i_clockGen (.clk(cpuClk));

    rv32Core i_rv32Core (
        .cpuClk(cpuClk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbDatI(wbDatI), .wbAck(wbAck),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireData(retireData)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
    endfunction

    function automatic logic [31:0] encI(input logic [2:0] f3, input int rd,
                                         input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opOpImm};
    endfunction

    function automatic logic [31:0] encU(input int rd, input int imm);
        return {imm[19:0], rd[4:0], opLui};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1,
                                         input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
    endfunction

    // Words past the program decode as custom no-ops
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        if (addr[31:2] < 30'(progLen)) begin
            return progMem[addr[6:2]];
        end
        return {addr[31:7] ^ {18'b0, addr[6:0]}, 7'b0001011};
    endfunction

    task automatic loadProgram();
        progMem[0]  = encI(f3AddSub, 1, 0, 5);
        progMem[1]  = encI(f3AddSub, 2, 1, -3);
        progMem[2]  = encR(f7Base, f3AddSub, 3, 1, 2);
        progMem[3]  = encR(f7Sub, f3AddSub, 4, 3, 1);
        progMem[4]  = encR(f7Base, f3Xor, 5, 4, 3);
        progMem[5]  = encR(f7Base, f3Or, 6, 5, 2);
        progMem[6]  = encR(f7Base, f3And, 7, 6, 3);
        progMem[7]  = encR(f7Base, f3Slt, 8, 4, 3);
        // Write aimed at x0 and a read of x0
        progMem[8]  = encI(f3AddSub, 0, 7, 9);
        progMem[9]  = encR(f7Base, f3AddSub, 9, 0, 7);
        progMem[10] = encU(10, 'hFFFFF);
        progMem[11] = encI(f3Slt, 11, 10, -1);
        progMem[12] = encI(f3Slt, 12, 1, -4);
        progMem[13] = encI(f3Xor, 13, 10, -1);
        progMem[14] = encI(f3Or, 14, 1, 'h0F0);
        progMem[15] = encI(f3And, 15, 13, 'h0F0);
        // BNE falls through and BEQ skips the next two
        progMem[16] = encB(f3Bne, 2, 4, 8);
        progMem[17] = encB(f3Beq, 2, 4, 12);
        progMem[18] = encI(f3AddSub, 16, 0, 1);
        progMem[19] = encI(f3AddSub, 17, 0, 2);
        progMem[20] = encR(f7Base, f3AddSub, 18, 16, 14);
        progMem[21] = 32'h0000_028B;
    endtask

    // ------------------------------
    // ISA reference model
    // ------------------------------
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            f3AddSub: return sub ? a - b : a + b;
            f3Slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3Xor:    return a ^ b;
            f3Or:     return a | b;
            f3And:    return a & b;
            default:  return 32'd0;
        endcase
    endfunction

    task automatic buildExpected();
        logic [31:0] mReg [32];
        rvInstr      ins;
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] res;
        logic [31:0] immI;
        logic [31:0] immB;
        logic        writes;
        logic        keepRd;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            mReg[k] = 32'd0;
        end
        pc    = 32'd0;
        steps = 0;
        while (pc[31:2] < 30'(progLen) && steps < 64) begin
            ins    = progMem[pc[6:2]];
            immI   = {{20{ins.i.imm12[11]}}, ins.i.imm12};
            immB   = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10to5,
                      ins.b.imm4to1, 1'b0};
            nextPc = pc + 32'd4;
            res    = 32'd0;
            writes = 1'b1;
            case (ins.r.opcode)
                opOp:    res = aluRef(ins.r.funct3, ins.r.funct7 == f7Sub,
                                      mReg[ins.r.rs1], mReg[ins.r.rs2]);
                opOpImm: res = aluRef(ins.i.funct3, 1'b0, mReg[ins.i.rs1], immI);
                opLui:   res = {ins.u.imm20, 12'b0};
                opBranch: begin
                    writes = 1'b0;
                    if ((mReg[ins.b.rs1] == mReg[ins.b.rs2]) == (ins.b.funct3 == f3Beq)) begin
                        nextPc = pc + immB;
                    end
                end
                default: writes = 1'b0;
            endcase
            keepRd = writes && (ins.r.rd != 5'd0);
            if (keepRd) begin
                mReg[ins.r.rd] = res;
            end
            expPcQ.push_back(pc);
            expRdQ.push_back(keepRd ? ins.r.rd : 5'd0);
            expDataQ.push_back(keepRd ? res : 32'd0);
            pc    = nextPc;
            steps = steps + 1;
        end
    endtask

    // Scoreboard head moves on each retirement
    initial begin
        loadProgram();
        buildExpected();
        headPc   <= expPcQ[0];
        headRd   <= expRdQ[0];
        headData <= expDataQ[0];
        forever begin
            @(posedge cpuClk);
            if (rstN && retireValid && expPcQ.size() > 0) begin
                void'(expPcQ.pop_front());
                void'(expRdQ.pop_front());
                void'(expDataQ.pop_front());
                if (expPcQ.size() > 0) begin
                    headPc   <= expPcQ[0];
                    headRd   <= expRdQ[0];
                    headData <= expDataQ[0];
                end
            end
        end
    end

    // Wishbone responder with 0 to 3 wait cycles
    initial begin
        logic [1:0] waitLeft;
        int         randVal;
        wbAck    = 1'b0;
        wbDatI   = 32'd0;
        seed     = 32'h5b51097a;
        randVal  = $random(seed);
        waitLeft = randVal[1:0];
        forever begin
            @(posedge cpuClk);
            if (wbAck) begin
                wbAck <= 1'b0;
            end else if (wbStb) begin
                if (waitLeft == 2'd0) begin
                    wbAck    <= 1'b1;
                    wbDatI   <= fetchWord(wbAdr);
                    randVal  = $random(seed);
                    waitLeft = randVal[1:0];
                end else begin
                    waitLeft = waitLeft - 2'd1;
                end
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    assert property (@(posedge cpuClk) armed && !rstN |-> !wbCyc && !wbStb && !retireValid)
        else reportFailure("bus or retire output active during reset");
    assert property (@(posedge cpuClk) $rose(rstN) |-> !wbCyc && !wbStb && !retireValid)
        else reportFailure("bus or retire output active right after reset");
    assert property (@(posedge cpuClk) $rose(rstN) |=> wbStb)
        else reportFailure("first fetch request did not start");
    assert property (@(posedge cpuClk) $rose(rstN) |=> wbAdr == resetPc)
        else reportFailure($sformatf("mismatch wbAdr: got %h expected %h",
                                     $sampled(wbAdr), resetPc));
    assert property (@(posedge cpuClk) disable iff (!rstN)
        wbStb && !wbAck |=> wbStb && wbCyc && $stable(wbAdr))
        else reportFailure("fetch request changed before its acknowledge");
    assert property (@(posedge cpuClk) disable iff (!rstN) retireValid |-> retirePc == headPc)
        else reportFailure($sformatf("mismatch retirePc: got %h expected %h",
                                     $sampled(retirePc), $sampled(headPc)));
    assert property (@(posedge cpuClk) disable iff (!rstN) retireValid |-> retireRd == headRd)
        else reportFailure($sformatf("mismatch retireRd: got %h expected %h",
                                     $sampled(retireRd), $sampled(headRd)));
    assert property (@(posedge cpuClk) disable iff (!rstN)
        retireValid && headRd != 5'd0 |-> retireData == headData)
        else reportFailure($sformatf("mismatch retireData: got %h expected %h",
                                     $sampled(retireData), $sampled(headData)));

    // Reset and then wait for each retirement in turn
    initial begin
        int   remaining;
        int   waitCycles;
        logic timedOut;
        armed    = 1'b0;
        rstN     = 1'b0;
        timedOut = 1'b0;
        @(posedge cpuClk);
        armed <= 1'b1;
        repeat (9) @(posedge cpuClk);
        rstN <= 1'b1;
        while (expPcQ.size() > 0 && !timedOut) begin
            remaining  = expPcQ.size();
            waitCycles = 0;
            while (expPcQ.size() == remaining && waitCycles < retireTimeout) begin
                @(posedge cpuClk);
                waitCycles = waitCycles + 1;
            end
            timedOut = (expPcQ.size() == remaining);
        end
        // Last retirement is checked at the edge before this
        @(negedge cpuClk);
        if (timedOut) begin
            reportFailure("timed out waiting for an instruction to retire");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
